// File: flist.f
+incdir+tests
verilog/backend_pkg.sv
verilog/issue_if.sv
verilog/result_if.sv
verilog/inst_decoder.sv
verilog/dispatch_stage.sv
verilog/execute_lane.sv
verilog/reg_file.sv
verilog/backend_top.sv
tests/tb_backend.sv

// File: run_sim.sh
#!/bin/bash
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

mkdir -p build &&
verilator --binary --timing -f flist.f --top-module tb_backend \
    -Mdir build -o sim_backend > build/compile.log 2>&1 &&
./build/sim_backend > build/sim.log 2>&1

grep -q "Test completed successfully" build/sim.log 2>/dev/null &&
    echo "PASS" ||
    { echo "FAIL (see build/compile.log and build/sim.log)"; exit 1; }

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per accepted pair with tab_inst0 in lane 0 and tab_inst1 in lane 1

localparam int NUM_PAIRS = 17;

logic [31:0] tab_inst0 [NUM_PAIRS];
logic [31:0] tab_inst1 [NUM_PAIRS];

function automatic logic [31:0] r3_word(logic [16:0] opc, int rd, int rj, int rk);
    return {opc, rk[4:0], rj[4:0], rd[4:0]};
endfunction

function automatic logic [31:0] addi_word(int rd, int rj, int imm);
    return {OPC_ADDI_W, imm[11:0], rj[4:0], rd[4:0]};
endfunction

task automatic load_table();
    tab_inst0[0]  = addi_word(1, 0, 5);
    tab_inst1[0]  = addi_word(2, 0, -3);
    tab_inst0[1]  = addi_word(3, 0, 2047);
    tab_inst1[1]  = addi_word(4, 0, -2048);
    tab_inst0[2]  = r3_word(OPC_3R_ADD_W, 5, 1, 2);    // distance two from row 0
    tab_inst1[2]  = r3_word(OPC_3R_SUB_W, 6, 1, 2);
    tab_inst0[3]  = r3_word(OPC_3R_SLT, 7, 2, 1);      // signed vs unsigned
    tab_inst1[3]  = r3_word(OPC_3R_SLTU, 8, 2, 1);
    tab_inst0[4]  = r3_word(OPC_3R_NOR, 9, 1, 2);
    tab_inst1[4]  = r3_word(OPC_3R_AND, 10, 3, 4);
    tab_inst0[5]  = r3_word(OPC_3R_OR, 11, 5, 6);
    tab_inst1[5]  = r3_word(OPC_3R_XOR, 12, 3, 4);
    tab_inst0[6]  = r3_word(OPC_3R_ADD_W, 13, 1, 0);
    tab_inst1[6]  = r3_word(OPC_3R_SUB_W, 14, 13, 1);  // splits the pair
    tab_inst0[7]  = addi_word(0, 1, 9);                // r0 write dropped
    tab_inst1[7]  = r3_word(OPC_3R_ADD_W, 15, 0, 1);
    tab_inst0[8]  = 32'h0000_0000;                     // unknown opcode
    tab_inst1[8]  = addi_word(16, 0, 1);
    tab_inst0[9]  = addi_word(17, 0, 1);
    tab_inst1[9]  = addi_word(17, 0, 2);               // same rd with lane 1 winning
    tab_inst0[10] = r3_word(OPC_3R_ADD_W, 18, 17, 17);
    tab_inst1[10] = addi_word(19, 17, 0);
    tab_inst0[11] = r3_word(OPC_3R_SLT, 20, 4, 3);
    tab_inst1[11] = r3_word(OPC_3R_ADD_W, 21, 17, 3);  // r17 through the read bypass
    tab_inst0[12] = addi_word(22, 22, -1);
    tab_inst1[12] = r3_word(OPC_3R_SUB_W, 23, 17, 3);  // r17 from the register array
    tab_inst0[13] = r3_word(OPC_3R_ADD_W, 24, 23, 22);
    tab_inst1[13] = r3_word(OPC_3R_XOR, 25, 24, 1);    // splits the pair
    tab_inst0[14] = addi_word(26, 25, 100);
    tab_inst1[14] = addi_word(27, 24, -100);
    tab_inst0[15] = r3_word(OPC_3R_SLTU, 28, 0, 26);
    tab_inst1[15] = r3_word(OPC_3R_SLT, 29, 26, 0);
    tab_inst0[16] = 32'hffff_ffff;                     // unknown opcode
    tab_inst1[16] = r3_word(OPC_3R_OR, 31, 29, 28);
endtask

`endif

// File: tests/tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend;
    import backend_pkg::*;

    `include "tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = 3 * NUM_PAIRS + 20;

    logic        clk;
    logic        rst_i;
    logic [31:0] pc0_i;
    logic [31:0] pc1_i;
    logic [31:0] inst0_i;
    logic [31:0] inst1_i;
    logic [1:0]  valid_i;
    logic        get_data_req_o;
    logic [1:0]  commit_valid_o;
    logic [1:0]  commit_we_o;
    logic [31:0] commit_pc0_o;
    logic [31:0] commit_pc1_o;
    logic [4:0]  commit_rd0_o;
    logic [4:0]  commit_rd1_o;
    logic [31:0] commit_data0_o;
    logic [31:0] commit_data1_o;

    int          cyc;
    int          seed;
    logic [31:0] model_regs [32];
    int          exp_due  [$];
    int          exp_lane [$];
    logic [31:0] exp_pc   [$];
    logic [31:0] exp_rd   [$];
    logic        exp_we   [$];
    logic [31:0] exp_data [$];

    backend_top UUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, commits still pending", cyc));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            fail_run($sformatf("** Error: %s actual 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    function automatic logic known_op(logic [31:0] inst);
        if (inst[31:22] == OPC_ADDI_W) return 1'b1;
        case (inst[31:15])
            OPC_3R_ADD_W, OPC_3R_SUB_W, OPC_3R_SLT, OPC_3R_SLTU,
            OPC_3R_NOR, OPC_3R_AND, OPC_3R_OR, OPC_3R_XOR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_value(logic [31:0] inst, logic [31:0] a, logic [31:0] b);
        logic [31:0] imm;
        imm = {{20{inst[21]}}, inst[21:10]};
        if (inst[31:22] == OPC_ADDI_W) return a + imm;
        case (inst[31:15])
            OPC_3R_ADD_W: return a + b;
            OPC_3R_SUB_W: return a - b;
            OPC_3R_SLT:   return {31'b0, $signed(a) < $signed(b)};
            OPC_3R_SLTU:  return {31'b0, a < b};
            OPC_3R_NOR:   return ~(a | b);
            OPC_3R_AND:   return a & b;
            OPC_3R_OR:    return a | b;
            default:      return a ^ b;
        endcase
    endfunction

    // runs one instruction through the model and queues its commit
    task automatic apply_model(input logic [31:0] inst, input logic [31:0] pc,
                               input int lane, input int due);
        logic        we;
        logic [31:0] val;
        we  = known_op(inst) && (inst[4:0] != 5'd0);
        val = model_value(inst, model_regs[inst[9:5]], model_regs[inst[14:10]]);
        exp_due.push_back(due);
        exp_lane.push_back(lane);
        exp_pc.push_back(pc);
        exp_rd.push_back({27'b0, inst[4:0]});
        exp_we.push_back(we);
        exp_data.push_back(val);
        if (we) model_regs[inst[4:0]] = val;
    endtask

    task automatic check_commit(input int lane, input logic [31:0] pc, input logic [4:0] rd,
                                input logic we, input logic [31:0] data);
        if (exp_due.size() == 0) begin
            fail_run($sformatf("unexpected commit on lane %0d at pc 0x%h", lane, pc));
        end
        check_value("commit cycle", cyc, exp_due[0]);
        check_value("commit lane", lane, exp_lane[0]);
        check_value($sformatf("commit_pc%0d_o", lane), pc, exp_pc[0]);
        check_value($sformatf("commit_rd%0d_o", lane), {27'b0, rd}, exp_rd[0]);
        check_value("commit_we_o", {31'b0, we}, {31'b0, exp_we[0]});
        if (exp_we[0]) check_value($sformatf("commit_data%0d_o", lane), data, exp_data[0]);
        void'(exp_due.pop_front());
        void'(exp_lane.pop_front());
        void'(exp_pc.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_we.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic check_outputs();
        if (commit_valid_o[0]) check_commit(0, commit_pc0_o, commit_rd0_o, commit_we_o[0],
                                            commit_data0_o);
        if (commit_valid_o[1]) check_commit(1, commit_pc1_o, commit_rd1_o, commit_we_o[1],
                                            commit_data1_o);
        if (exp_due.size() != 0 && exp_due[0] < cyc) begin
            fail_run($sformatf("commit for pc 0x%h never appeared", exp_pc[0]));
        end
    endtask

    initial begin
        int          idx;
        logic        split;
        logic        exp_req;
        logic [31:0] pc;
        seed    = 32'hf4aa;
        clk     = 1'b0;
        rst_i   = 1'b1;
        cyc     = 0;
        pc0_i   = '0;
        pc1_i   = '0;
        inst0_i = '0;
        inst1_i = '0;
        valid_i = '0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        load_table();
        repeat (2) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        check_value("commit_valid_o", {30'b0, commit_valid_o}, 32'h0);
        check_value("get_data_req_o", {31'b0, get_data_req_o}, 32'h1);
        idx     = 0;
        exp_req = 1'b1;
        while (idx < NUM_PAIRS || exp_due.size() != 0) begin
            check_outputs();
            check_value("get_data_req_o", {31'b0, get_data_req_o}, {31'b0, exp_req});
            if (get_data_req_o && idx < NUM_PAIRS) begin
                pc      = 32'h1c00_0000 + 32'(idx * 8);
                pc0_i   = pc;
                pc1_i   = pc + 32'd4;
                inst0_i = tab_inst0[idx];
                inst1_i = tab_inst1[idx];
                valid_i = 2'b11;
                // lane 1 sourcing lane 0's destination issues a cycle late
                split = known_op(inst0_i) && (inst0_i[4:0] != 5'd0) &&
                        ((inst1_i[9:5] == inst0_i[4:0]) ||
                         (inst1_i[31:22] != OPC_ADDI_W && inst1_i[14:10] == inst0_i[4:0]));
                apply_model(inst0_i, pc0_i, 0, cyc + 2);
                apply_model(inst1_i, pc1_i, 1, split ? cyc + 3 : cyc + 2);
                idx++;
                exp_req = !split;   // one idle request cycle per split
            end else begin
                pc0_i   = $random(seed);   // junk pair that must never commit
                pc1_i   = $random(seed);
                inst0_i = $random(seed);
                inst1_i = $random(seed);
                valid_i = (idx < NUM_PAIRS) ? 2'b11 : 2'b00;
                exp_req = 1'b1;
            end
            @(negedge clk);
        end
        check_outputs();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int XLEN         = 32;
    localparam int ISSUE_WIDTH  = 2;
    localparam int REG_ADDR_W   = 5;
    localparam int NUM_REGS     = 32;
    localparam int NUM_RD_PORTS = 2 * ISSUE_WIDTH;   // rj and rk per lane

    // 3R major opcodes, inst[31:15]
    localparam logic [16:0] OPC_3R_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_3R_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_3R_SLT   = 17'h00024;
    localparam logic [16:0] OPC_3R_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_3R_NOR   = 17'h00028;
    localparam logic [16:0] OPC_3R_AND   = 17'h00029;
    localparam logic [16:0] OPC_3R_OR    = 17'h0002A;
    localparam logic [16:0] OPC_3R_XOR   = 17'h0002B;

    localparam logic [9:0] OPC_ADDI_W = 10'h00A;      // 2RI12, inst[31:22]

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOP
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;       // low for rd 0 and nop
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;      // sign-extended si12
    } decoded_slot_t;

endpackage

`default_nettype wire

// File: verilog/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic [backend_pkg::XLEN-1:0]        pc0_i,
    input  logic [backend_pkg::XLEN-1:0]        pc1_i,
    input  logic [backend_pkg::XLEN-1:0]        inst0_i,
    input  logic [backend_pkg::XLEN-1:0]        inst1_i,
    input  logic [backend_pkg::ISSUE_WIDTH-1:0] valid_i,
    output logic                                get_data_req_o,
    output logic [backend_pkg::ISSUE_WIDTH-1:0] commit_valid_o,
    output logic [backend_pkg::ISSUE_WIDTH-1:0] commit_we_o,
    output logic [backend_pkg::XLEN-1:0]        commit_pc0_o,
    output logic [backend_pkg::XLEN-1:0]        commit_pc1_o,
    output logic [backend_pkg::REG_ADDR_W-1:0]  commit_rd0_o,
    output logic [backend_pkg::REG_ADDR_W-1:0]  commit_rd1_o,
    output logic [backend_pkg::XLEN-1:0]        commit_data0_o,
    output logic [backend_pkg::XLEN-1:0]        commit_data1_o
);
    import backend_pkg::*;

    logic [NUM_RD_PORTS-1:0][REG_ADDR_W-1:0] rf_rd_addr;
    logic [NUM_RD_PORTS-1:0][XLEN-1:0]       rf_rd_data;

    issue_if  issue_bus ();
    result_if result_bus ();

    dispatch_stage u_dispatch (
        .clk            (clk),
        .rst_i          (rst_i),
        .pc0_i          (pc0_i),
        .pc1_i          (pc1_i),
        .inst0_i        (inst0_i),
        .inst1_i        (inst1_i),
        .valid_i        (valid_i),
        .get_data_req_o (get_data_req_o),
        .rd_addr_o      (rf_rd_addr),
        .rd_data_i      (rf_rd_data),
        .issue          (issue_bus.dispatch)
    );

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_lane
        execute_lane #(
            .LANE (g)
        ) u_lane (
            .clk   (clk),
            .rst_i (rst_i),
            .issue (issue_bus.lane),
            .fwd   (result_bus.sink),   // both lanes' results for forwarding
            .res   (result_bus.lane)
        );
    end

    reg_file u_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .rd_addr_i (rf_rd_addr),
        .rd_data_o (rf_rd_data),
        .wr        (result_bus.sink)
    );

    // commit port is the result register itself
    assign commit_valid_o = result_bus.valid;
    assign commit_we_o    = result_bus.we;
    assign commit_pc0_o   = result_bus.pc[0];
    assign commit_pc1_o   = result_bus.pc[1];
    assign commit_rd0_o   = result_bus.rd[0];
    assign commit_rd1_o   = result_bus.rd[1];
    assign commit_data0_o = result_bus.data[0];
    assign commit_data1_o = result_bus.data[1];

endmodule

`default_nettype wire

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  logic                                     clk,
    input  logic                                     rst_i,
    input  logic [backend_pkg::XLEN-1:0]             pc0_i,
    input  logic [backend_pkg::XLEN-1:0]             pc1_i,
    input  logic [backend_pkg::XLEN-1:0]             inst0_i,
    input  logic [backend_pkg::XLEN-1:0]             inst1_i,
    input  logic [backend_pkg::ISSUE_WIDTH-1:0]      valid_i,
    output logic                                     get_data_req_o,
    output logic [backend_pkg::NUM_RD_PORTS-1:0][backend_pkg::REG_ADDR_W-1:0] rd_addr_o,
    input  logic [backend_pkg::NUM_RD_PORTS-1:0][backend_pkg::XLEN-1:0]       rd_data_i,
    issue_if.dispatch                                issue
);
    import backend_pkg::*;

    decoded_slot_t   dec     [ISSUE_WIDTH];
    decoded_slot_t   disp_q  [ISSUE_WIDTH];
    decoded_slot_t   hold_q;                     // lane 1 waiting for its partner
    decoded_slot_t   slot1;
    logic [XLEN-1:0] src_a_q [ISSUE_WIDTH];
    logic [XLEN-1:0] src_b_q [ISSUE_WIDTH];
    logic            accept;
    logic            raw_hit;

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_dec
        inst_decoder u_dec (
            .pc_i    (g == 0 ? pc0_i : pc1_i),
            .inst_i  (g == 0 ? inst0_i : inst1_i),
            .valid_i (valid_i[g]),
            .slot_o  (dec[g])
        );
    end

    assign accept = get_data_req_o;   // pair is consumed on this edge

    // lane 1 sources lane 0's result so the pair can't issue together
    assign raw_hit = dec[0].valid && dec[0].we && dec[1].valid &&
                     ((dec[1].rj == dec[0].rd) ||
                      (!dec[1].use_imm && (dec[1].rk == dec[0].rd)));

    assign slot1 = hold_q.valid ? hold_q : dec[1];

    assign rd_addr_o[0] = dec[0].rj;
    assign rd_addr_o[1] = dec[0].rk;
    assign rd_addr_o[2] = slot1.rj;   // held slot reads in its own cycle
    assign rd_addr_o[3] = slot1.rk;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            get_data_req_o <= 1'b0;
            hold_q         <= '0;
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                disp_q[i]  <= '0;
                src_a_q[i] <= '0;
                src_b_q[i] <= '0;
            end
        end else begin
            get_data_req_o <= !(accept && raw_hit);   // one bubble per split
            if (hold_q.valid) begin
                disp_q[0].valid <= 1'b0;
                disp_q[1]       <= hold_q;
                src_a_q[1]      <= rd_data_i[2];
                src_b_q[1]      <= rd_data_i[3];
                hold_q.valid    <= 1'b0;
            end else if (accept) begin
                disp_q[0]       <= dec[0];
                src_a_q[0]      <= rd_data_i[0];
                src_b_q[0]      <= rd_data_i[1];
                disp_q[1]       <= dec[1];
                disp_q[1].valid <= dec[1].valid && !raw_hit;
                src_a_q[1]      <= rd_data_i[2];
                src_b_q[1]      <= rd_data_i[3];
                if (raw_hit) begin
                    hold_q <= dec[1];
                end
            end else begin
                disp_q[0].valid <= 1'b0;
                disp_q[1].valid <= 1'b0;
            end
        end
    end

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_issue
        assign issue.valid[g]      = disp_q[g].valid;
        assign issue.pc[g]         = disp_q[g].pc;
        assign issue.op[g]         = disp_q[g].op;
        assign issue.rd[g]         = disp_q[g].rd;
        assign issue.we[g]         = disp_q[g].we;
        assign issue.src_a_addr[g] = disp_q[g].rj;
        assign issue.src_b_addr[g] = disp_q[g].rk;
        assign issue.src_a[g]      = src_a_q[g];
        assign issue.src_b[g]      = src_b_q[g];
        assign issue.use_imm[g]    = disp_q[g].use_imm;
        assign issue.imm[g]        = disp_q[g].imm;
    end

endmodule

`default_nettype wire

// File: verilog/execute_lane.sv
`timescale 1ns/1ps
`default_nettype none

module execute_lane #(
    parameter int LANE = 0
) (
    input  logic      clk,
    input  logic      rst_i,
    issue_if.lane     issue,
    result_if.sink    fwd,
    result_if.lane    res
);
    import backend_pkg::*;

    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_out;
    logic                  valid_q;
    logic                  we_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       data_q;
    logic [XLEN-1:0]       pc_q;

    // later lane overrides, so lane 1 has priority over lane 0
    always_comb begin
        op_a = issue.src_a[LANE];
        op_b = issue.src_b[LANE];
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (fwd.valid[i] && fwd.we[i] && (fwd.rd[i] == issue.src_a_addr[LANE])) begin
                op_a = fwd.data[i];
            end
            if (fwd.valid[i] && fwd.we[i] && (fwd.rd[i] == issue.src_b_addr[LANE])) begin
                op_b = fwd.data[i];
            end
        end
    end

    assign alu_b = issue.use_imm[LANE] ? issue.imm[LANE] : op_b;

    always_comb begin
        case (issue.op[LANE])
            ALU_ADD:  alu_out = op_a + alu_b;
            ALU_SUB:  alu_out = op_a - alu_b;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < alu_b};
            ALU_NOR:  alu_out = ~(op_a | alu_b);
            ALU_AND:  alu_out = op_a & alu_b;
            ALU_OR:   alu_out = op_a | alu_b;
            ALU_XOR:  alu_out = op_a ^ alu_b;
            default:  alu_out = '0;              // nop
        endcase
    end

    // result register doubles as the writeback point
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
            rd_q    <= '0;
            data_q  <= '0;
            pc_q    <= '0;
        end else begin
            valid_q <= issue.valid[LANE];
            we_q    <= issue.valid[LANE] && issue.we[LANE];
            rd_q    <= issue.rd[LANE];
            data_q  <= alu_out;
            pc_q    <= issue.pc[LANE];
        end
    end

    assign res.valid[LANE] = valid_q;
    assign res.we[LANE]    = we_q;
    assign res.rd[LANE]    = rd_q;
    assign res.data[LANE]  = data_q;
    assign res.pc[LANE]    = pc_q;

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic [backend_pkg::XLEN-1:0] pc_i,
    input  logic [backend_pkg::XLEN-1:0] inst_i,
    input  logic                         valid_i,
    output backend_pkg::decoded_slot_t   slot_o
);
    import backend_pkg::*;

    alu_op_e op;
    logic    is_addi;

    assign is_addi = (inst_i[31:22] == OPC_ADDI_W);

    always_comb begin
        if (is_addi) begin
            op = ALU_ADD;
        end else begin
            case (inst_i[31:15])
                OPC_3R_ADD_W: op = ALU_ADD;
                OPC_3R_SUB_W: op = ALU_SUB;
                OPC_3R_SLT:   op = ALU_SLT;
                OPC_3R_SLTU:  op = ALU_SLTU;
                OPC_3R_NOR:   op = ALU_NOR;
                OPC_3R_AND:   op = ALU_AND;
                OPC_3R_OR:    op = ALU_OR;
                OPC_3R_XOR:   op = ALU_XOR;
                default:      op = ALU_NOP;    // anything else retires silently
            endcase
        end
    end

    always_comb begin
        slot_o.valid   = valid_i;
        slot_o.pc      = pc_i;
        slot_o.op      = op;
        slot_o.rd      = inst_i[4:0];
        slot_o.rj      = inst_i[9:5];
        slot_o.rk      = inst_i[14:10];
        slot_o.use_imm = is_addi;
        slot_o.imm     = {{(XLEN-12){inst_i[21]}}, inst_i[21:10]};
        // r0 is hardwired and never written
        slot_o.we      = (op != ALU_NOP) && (inst_i[4:0] != '0);
    end

endmodule

`default_nettype wire

// File: verilog/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import backend_pkg::*;

    logic [ISSUE_WIDTH-1:0] valid;
    logic [XLEN-1:0]        pc         [ISSUE_WIDTH];
    alu_op_e                op         [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0]  rd         [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] we;
    logic [REG_ADDR_W-1:0]  src_a_addr [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0]  src_b_addr [ISSUE_WIDTH];
    logic [XLEN-1:0]        src_a      [ISSUE_WIDTH];   // as read at dispatch
    logic [XLEN-1:0]        src_b      [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] use_imm;
    logic [XLEN-1:0]        imm        [ISSUE_WIDTH];

    modport dispatch (output valid, pc, op, rd, we, src_a_addr, src_b_addr,
                      src_a, src_b, use_imm, imm);
    modport lane (input valid, pc, op, rd, we, src_a_addr, src_b_addr,
                  src_a, src_b, use_imm, imm);

endinterface

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                                                              clk,
    input  logic                                                              rst_i,
    input  logic [backend_pkg::NUM_RD_PORTS-1:0][backend_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [backend_pkg::NUM_RD_PORTS-1:0][backend_pkg::XLEN-1:0]       rd_data_o,
    result_if.sink                                                            wr
);
    import backend_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wr.valid[i] && wr.we[i]) begin
                    regs_q[wr.rd[i]] <= wr.data[i];   // lane 1 lands last on equal rd
                end
            end
        end
    end

    // write-through so a read sees the value committed this cycle
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rd_data_o[p] = regs_q[rd_addr_i[p]];
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wr.valid[i] && wr.we[i] && (wr.rd[i] == rd_addr_i[p])) begin
                    rd_data_o[p] = wr.data[i];
                end
            end
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;   // r0
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface result_if;
    import backend_pkg::*;

    logic [ISSUE_WIDTH-1:0] valid;
    logic [ISSUE_WIDTH-1:0] we;
    logic [REG_ADDR_W-1:0]  rd   [ISSUE_WIDTH];
    logic [XLEN-1:0]        data [ISSUE_WIDTH];
    logic [XLEN-1:0]        pc   [ISSUE_WIDTH];

    modport lane (output valid, we, rd, data, pc);
    modport sink (input valid, we, rd, data, pc);   // regfile write and forwarding

endinterface

`default_nettype wire
